// File: x25519_ladder_ctrl.f
+incdir+tb
design/ladder_pkg.sv
design/ladder_step_rom.sv
design/ladder_key_bit.sv
design/ladder_step_seq.sv
design/x25519_ladder_ctrl.sv
tb/tb_ladder_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the ladder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ladder_ctrl \
    -f x25519_ladder_ctrl.f -o sim_ladder

./obj_dir/sim_ladder > sim.log 2>&1 || true
cat sim.log

if grep -q '^TB PASSED$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: tb/ladder_ref.svh
// include inside the testbench module once lfsr, ref_mem and both expected queues exist
`ifndef LADDER_REF_SVH
`define LADDER_REF_SVH

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic ladder_pkg::word_t rand_bits(input int n);
    ladder_pkg::word_t v;
    int                i;
    v = '0;
    for (i = 0; i < n; i++)
        v = {v[ladder_pkg::WORD_W-2:0], lfsr_bit()};
    return v;
endfunction

// ladder table as {op, src_a, src_b, dst}; a swap also writes src_a
function automatic logic [16:0] table_row(input int idx);
    case (idx)
        0:  return {ladder_pkg::OP_ADD,  5'd11, 5'd18, 5'd18};  // key fetch, no write
        1:  return {ladder_pkg::OP_SWAP, 5'd7,  5'd9,  5'd9};
        2:  return {ladder_pkg::OP_SWAP, 5'd8,  5'd10, 5'd10};
        3:  return {ladder_pkg::OP_ADD,  5'd7,  5'd8,  5'd20};  // A
        4:  return {ladder_pkg::OP_MUL,  5'd20, 5'd20, 5'd22};  // AA
        5:  return {ladder_pkg::OP_SUB,  5'd8,  5'd7,  5'd21};  // B = X2 - Z2
        6:  return {ladder_pkg::OP_MUL,  5'd21, 5'd21, 5'd23};  // BB
        7:  return {ladder_pkg::OP_SUB,  5'd23, 5'd22, 5'd24};  // E = AA - BB
        8:  return {ladder_pkg::OP_MUL,  5'd22, 5'd23, 5'd7};
        9:  return {ladder_pkg::OP_MUL,  5'd24, 5'd31, 5'd23};
        10: return {ladder_pkg::OP_ADD,  5'd22, 5'd23, 5'd23};
        11: return {ladder_pkg::OP_MUL,  5'd24, 5'd23, 5'd8};
        12: return {ladder_pkg::OP_ADD,  5'd9,  5'd10, 5'd22};  // C
        13: return {ladder_pkg::OP_SUB,  5'd10, 5'd9,  5'd23};  // D = X3 - Z3
        14: return {ladder_pkg::OP_MUL,  5'd22, 5'd21, 5'd21};
        15: return {ladder_pkg::OP_MUL,  5'd23, 5'd20, 5'd20};
        16: return {ladder_pkg::OP_ADD,  5'd20, 5'd21, 5'd23};
        17: return {ladder_pkg::OP_MUL,  5'd23, 5'd23, 5'd9};
        18: return {ladder_pkg::OP_SUB,  5'd21, 5'd20, 5'd22};  // DA - CB
        19: return {ladder_pkg::OP_MUL,  5'd22, 5'd22, 5'd22};
        default: return {ladder_pkg::OP_MUL, 5'd6, 5'd22, 5'd10};  // Z3
    endcase
endfunction

// stand-in field ALU, plain integer arithmetic mod 2^256
function automatic void fake_alu(input ladder_pkg::alu_op_e op, input logic sw,
                                 input ladder_pkg::word_t a, input ladder_pkg::word_t b,
                                 output ladder_pkg::word_t res,
                                 output ladder_pkg::word_t res_swap);
    res_swap = sw ? b : a;
    case (op)
        ladder_pkg::OP_ADD: res = a + b;
        ladder_pkg::OP_SUB: res = b - a;
        ladder_pkg::OP_MUL: res = a * b;  // low half of the product
        default:            res = sw ? a : b;
    endcase
endfunction

// walks bits 254..0 on ref_mem, queues every start and write in order
function automatic void build_expected();
    logic [16:0]         row;
    ladder_pkg::alu_op_e op;
    ladder_pkg::addr_t   a;
    ladder_pkg::addr_t   b;
    ladder_pkg::word_t   res;
    ladder_pkg::word_t   res_swap;
    logic                prev_bit;
    logic                sw;
    int                  i;
    int                  s;
    prev_bit = 1'b0;
    sw       = 1'b0;
    for (i = ladder_pkg::BIT_TOP; i >= 0; i--)
    begin
        for (s = 0; s < ladder_pkg::NUM_STEPS; s++)
        begin
            row = table_row(s);
            op  = ladder_pkg::alu_op_e'(row[16:15]);
            a   = row[14:10];
            b   = row[9:5];
            exp_start.push_back(start_ev_t'{op: op, a: a, b: b, sw: sw});
            fake_alu(op, sw, ref_mem[a], ref_mem[b], res, res_swap);
            if (s == 0)
            begin
                sw       = prev_bit ^ res[i];
                prev_bit = res[i];
            end
            else
            begin
                ref_mem[row[4:0]] = res;
                exp_wr.push_back(wr_ev_t'{addr: row[4:0], data: res});
                if (op == ladder_pkg::OP_SWAP)
                begin
                    ref_mem[a] = res_swap;  // second write of a swap
                    exp_wr.push_back(wr_ev_t'{addr: a, data: res_swap});
                end
            end
        end
    end
endfunction

`endif

// File: tb/tb_ladder_ctrl.sv
// ALU model answers 1 to 8 cycles after start; RAM word 18 is kept at 0 and word 31 holds a24
`timescale 1ns/1ps

module tb_ladder_ctrl;

    typedef struct packed {
        ladder_pkg::alu_op_e op;
        ladder_pkg::addr_t   a;   // read the cycle before start
        ladder_pkg::addr_t   b;   // read in the start cycle
        logic                sw;
    } start_ev_t;

    typedef struct packed {
        ladder_pkg::addr_t addr;
        ladder_pkg::word_t data;
    } wr_ev_t;

    // 2 runs of 255 bits with 21 steps of at most 14 cycles
    localparam int WATCHDOG_CYC = 2 * 255 * 21 * 14 + 1000;

    logic                 clk     = 1'b0;
    logic                 rst     = 1'b1;
    logic                 start   = 1'b0;
    logic                 done;
    ladder_pkg::addr_t    rd_addr;
    ladder_pkg::alu_req_t alu_req;
    ladder_pkg::alu_rsp_t alu_rsp = '0;
    ladder_pkg::ram_wr_t  ram_wr;

    logic [15:0]       lfsr = 16'd33975;
    ladder_pkg::word_t mem [32];
    ladder_pkg::word_t ref_mem [32];
    start_ev_t         exp_start [$];
    wr_ev_t            exp_wr [$];

    ladder_pkg::addr_t model_prev_addr;
    ladder_pkg::word_t alu_res      = '0;
    ladder_pkg::word_t alu_res_swap = '0;
    int                cyc          = 0;
    int                rsp_due      = -1;

    ladder_pkg::addr_t cmp_prev_addr;
    start_ev_t         s_ev;
    wr_ev_t            w_ev;
    logic              z3_written = 1'b0;  // previous cycle wrote Z3
    int                done_cnt   = 0;

    `include "ladder_ref.svh"

    x25519_ladder_ctrl dut_i (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .done    (done),
        .rd_addr (rd_addr),
        .alu_req (alu_req),
        .alu_rsp (alu_rsp),
        .ram_wr  (ram_wr)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input ladder_pkg::addr_t got,
                              input ladder_pkg::addr_t exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input ladder_pkg::word_t got,
                              input ladder_pkg::word_t exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_op(input string name, input ladder_pkg::alu_op_e got,
                            input ladder_pkg::alu_op_e exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // RAM and ALU models
    always @(negedge clk)
    begin
        if (ram_wr.en === 1'b1)
            mem[ram_wr.addr] = ram_wr.data;
        if (alu_req.start === 1'b1)
        begin
            fake_alu(alu_req.op, alu_req.swap, mem[model_prev_addr], mem[rd_addr],
                     alu_res, alu_res_swap);
            rsp_due = cyc + 1 + int'(rand_bits(3));  // 1 to 8 cycles
        end
        model_prev_addr = rd_addr;
    end

    always @(posedge clk)
    begin
        #1;
        cyc = cyc + 1;
        alu_rsp.vld      = cyc == rsp_due;
        alu_rsp.res      = alu_res;
        alu_rsp.res_swap = alu_res_swap;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare DUT events with the expected streams
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (ram_wr.en !== 1'b0)
            begin
                if (exp_wr.size() == 0)
                    stop_run("RAM write seen while no write was expected");
                w_ev = exp_wr.pop_front();
                check_addr("ram_wr.addr", ram_wr.addr, w_ev.addr);
                check_word("ram_wr.data", ram_wr.data, w_ev.data);
            end
            if (alu_req.start !== 1'b0)
            begin
                if (exp_start.size() == 0)
                    stop_run("ALU start seen while no operation was expected");
                s_ev = exp_start.pop_front();
                check_op("alu_req.op", alu_req.op, s_ev.op);
                check_addr("rd_addr before start", cmp_prev_addr, s_ev.a);
                check_addr("rd_addr at start", rd_addr, s_ev.b);
                if (s_ev.op == ladder_pkg::OP_SWAP)
                    check_bit("alu_req.swap", alu_req.swap, s_ev.sw);
            end
            if (done !== 1'b0)
            begin
                if (!z3_written || exp_wr.size() != 0 || exp_start.size() != 0)
                    stop_run("done pulse not in the cycle after the final Z3 write");
                done_cnt = done_cnt + 1;
            end
        end
        z3_written    = ram_wr.en === 1'b1 && ram_wr.addr == ladder_pkg::A_Z3;
        cmp_prev_addr = rd_addr;
    end

    initial
    begin
        #(WATCHDOG_CYC * 10);
        stop_run("timeout, the ladder runs did not finish in time");
    end

    initial
    begin : stimulus
        ladder_pkg::word_t key;
        int                i;
        int                run;
        for (i = 0; i < 32; i++)
            mem[i] = rand_bits(ladder_pkg::WORD_W);
        mem[ladder_pkg::A_ZERO] = '0;
        mem[ladder_pkg::A_A24]  = 256'd121665;
        ref_mem = mem;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        repeat (20) @(posedge clk);  // idle with start low
        for (run = 1; run <= 2; run++)
        begin
            key = rand_bits(ladder_pkg::WORD_W);
            mem[ladder_pkg::A_K_NUM]     = key;
            ref_mem[ladder_pkg::A_K_NUM] = key;
            build_expected();
            #1 start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            wait (done_cnt == run);
            repeat (4) @(posedge clk);
            check_word("X2 word", mem[ladder_pkg::A_X2], ref_mem[ladder_pkg::A_X2]);
            check_word("Z2 word", mem[ladder_pkg::A_Z2], ref_mem[ladder_pkg::A_Z2]);
            check_word("X3 word", mem[ladder_pkg::A_X3], ref_mem[ladder_pkg::A_X3]);
            check_word("Z3 word", mem[ladder_pkg::A_Z3], ref_mem[ladder_pkg::A_Z3]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: design/x25519_ladder_ctrl.sv
// sequencer only; RAM read latency is one cycle and the field ALU latches its own operands
`timescale 1ns/1ps

module x25519_ladder_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,    // level, sampled when idle
    output logic                 done,     // one-cycle pulse
    output ladder_pkg::addr_t    rd_addr,
    output ladder_pkg::alu_req_t alu_req,
    input  ladder_pkg::alu_rsp_t alu_rsp,
    output ladder_pkg::ram_wr_t  ram_wr
);

    ladder_pkg::step_idx_t step_idx;
    ladder_pkg::step_t     step;
    logic                  iter_start;
    logic                  key_vld;
    logic                  iter_end;
    logic                  swap;
    logic                  last_iter;

    ladder_step_seq seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .step       (step),
        .swap       (swap),
        .last_iter  (last_iter),
        .alu_rsp    (alu_rsp),
        .step_idx   (step_idx),
        .iter_start (iter_start),
        .key_vld    (key_vld),
        .iter_end   (iter_end),
        .done       (done),
        .rd_addr    (rd_addr),
        .alu_req    (alu_req),
        .ram_wr     (ram_wr)
    );

    ladder_step_rom rom_i (
        .step_idx (step_idx),
        .step     (step)
    );

    // key word comes straight off the ALU result bus
    ladder_key_bit key_i (
        .clk        (clk),
        .rst        (rst),
        .iter_start (iter_start),
        .key_vld    (key_vld),
        .key_word   (alu_rsp.res),
        .iter_end   (iter_end),
        .swap       (swap),
        .last_iter  (last_iter)
    );

endmodule

// File: design/ladder_step_seq.sv
// one ALU op in flight at a time; alu_rsp.vld must not arrive before the cycle after start
`timescale 1ns/1ps

module ladder_step_seq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  ladder_pkg::step_t     step,
    input  logic                  swap,
    input  logic                  last_iter,
    input  ladder_pkg::alu_rsp_t  alu_rsp,
    output ladder_pkg::step_idx_t step_idx,
    output logic                  iter_start,
    output logic                  key_vld,
    output logic                  iter_end,
    output logic                  done,
    output ladder_pkg::addr_t     rd_addr,
    output ladder_pkg::alu_req_t  alu_req,
    output ladder_pkg::ram_wr_t   ram_wr
);

    ladder_pkg::seq_state_e state;
    ladder_pkg::seq_state_e state_nxt;
    ladder_pkg::seq_state_e step_next;  // where a finished step goes
    ladder_pkg::word_t      res_q;
    ladder_pkg::word_t      res_swap_q;
    logic                   rsp_hit;
    logic                   last_step;
    logic                   step_end;

    assign rsp_hit   = (state == ladder_pkg::S_WAIT) && alu_rsp.vld;
    assign last_step = int'(step_idx) == ladder_pkg::NUM_STEPS - 1;
    assign step_next = last_step ? ladder_pkg::S_NEXT : ladder_pkg::S_RD_A;

    // current step has done its last write, or has none
    assign step_end = (rsp_hit && step.wr_cnt == 2'd0)
                    || (state == ladder_pkg::S_WR_1 && step.wr_cnt != 2'd2)
                    || (state == ladder_pkg::S_WR_2);

    assign iter_start = (state == ladder_pkg::S_IDLE) && start;
    assign key_vld    = rsp_hit && step.key_step;
    assign iter_end   = state == ladder_pkg::S_NEXT;

    ////////////////////////////////////////////////////////////////////////////
    // step FSM
    always_comb
    begin
        state_nxt = state;
        case (state)
            ladder_pkg::S_IDLE: if (start) state_nxt = ladder_pkg::S_RD_A;
            ladder_pkg::S_RD_A: state_nxt = ladder_pkg::S_RD_B;
            ladder_pkg::S_RD_B: state_nxt = ladder_pkg::S_WAIT;
            ladder_pkg::S_WAIT:
            begin
                if (alu_rsp.vld)
                    state_nxt = (step.wr_cnt == 2'd0) ? step_next : ladder_pkg::S_WR_1;
            end
            ladder_pkg::S_WR_1:
            begin
                state_nxt = (step.wr_cnt == 2'd2) ? ladder_pkg::S_WR_2 : step_next;
            end
            ladder_pkg::S_WR_2: state_nxt = step_next;
            ladder_pkg::S_NEXT: state_nxt = last_iter ? ladder_pkg::S_DONE : ladder_pkg::S_RD_A;
            default:            state_nxt = ladder_pkg::S_IDLE;  // S_DONE
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ladder_pkg::S_IDLE;
            step_idx <= '0;
            done     <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            done  <= iter_end && last_iter;  // high while in S_DONE
            if (iter_start || iter_end)
                step_idx <= '0;
            else if (step_end && !last_step)
                step_idx <= step_idx + 1'b1;
        end
    end

    // ALU results, held for the write states
    always_ff @(posedge clk)
    begin
        if (rsp_hit)
        begin
            res_q      <= alu_rsp.res;
            res_swap_q <= alu_rsp.res_swap;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered RAM and ALU outputs, one cycle behind the state
    always_ff @(posedge clk)
    begin
        if (state == ladder_pkg::S_RD_A)
            rd_addr <= step.src_a;
        else if (state == ladder_pkg::S_RD_B)
            rd_addr <= step.src_b;   // operand b, read in the start cycle
        ram_wr.addr <= (state == ladder_pkg::S_WR_2) ? step.dst2 : step.dst;
        ram_wr.data <= (state == ladder_pkg::S_WR_2) ? res_swap_q : res_q;

        if (rst)
        begin
            alu_req.start <= 1'b0;
            alu_req.op    <= ladder_pkg::OP_ADD;
            alu_req.swap  <= 1'b0;
            ram_wr.en     <= 1'b0;
        end
        else
        begin
            alu_req.start <= state == ladder_pkg::S_RD_B;
            if (state == ladder_pkg::S_RD_B)
            begin
                alu_req.op   <= step.op;
                alu_req.swap <= swap;  // only meaningful on OP_SWAP
            end
            ram_wr.en <= (state == ladder_pkg::S_WR_1) || (state == ladder_pkg::S_WR_2);
        end
    end

endmodule

// File: design/ladder_key_bit.sv
// swap chain restarts at 0 on iter_start; key_word is only looked at in the key_vld cycle
`timescale 1ns/1ps

module ladder_key_bit (
    input  logic              clk,
    input  logic              rst,
    input  logic              iter_start,  // new run
    input  logic              key_vld,
    input  ladder_pkg::word_t key_word,
    input  logic              iter_end,
    output logic              swap,
    output logic              last_iter
);

    ladder_pkg::bit_idx_t bit_cnt;   // scalar bit of the current iteration
    logic                 prev_bit;
    logic                 cur_bit;

    assign cur_bit   = key_word[bit_cnt];
    assign last_iter = bit_cnt == '0;

    ////////////////////////////////////////////////////////////////////////////
    // bit counter, 254 down to 0
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bit_cnt <= ladder_pkg::bit_idx_t'(ladder_pkg::BIT_TOP);
        end
        else if (iter_start)
        begin
            bit_cnt <= ladder_pkg::bit_idx_t'(ladder_pkg::BIT_TOP);
        end
        else if (iter_end && !last_iter)
        begin
            bit_cnt <= bit_cnt - 1'b1;  // holds at 0 after the final iteration
        end
    end

    // swap = previous bit ^ current bit
    always_ff @(posedge clk)
    begin
        if (rst || iter_start)
        begin
            prev_bit <= 1'b0;
            swap     <= 1'b0;
        end
        else if (key_vld)
        begin
            swap     <= prev_bit ^ cur_bit;
            prev_bit <= cur_bit;
        end
    end

endmodule

// File: design/ladder_step_rom.sv
// combinational only; indexes past the last step return an idle entry with no writes
`timescale 1ns/1ps

module ladder_step_rom (
    input  ladder_pkg::step_idx_t step_idx,
    output ladder_pkg::step_t     step
);

    // single-write arithmetic step
    function automatic ladder_pkg::step_t mk(input ladder_pkg::alu_op_e op,
                                             input ladder_pkg::addr_t   a,
                                             input ladder_pkg::addr_t   b,
                                             input ladder_pkg::addr_t   d);
        mk = '{op: op, src_a: a, src_b: b, dst: d, dst2: d, wr_cnt: 2'd1, key_step: 1'b0};
    endfunction

    // b gets res and a gets res_swap, so no swap leaves both words in place
    function automatic ladder_pkg::step_t mk_swap(input ladder_pkg::addr_t a,
                                                  input ladder_pkg::addr_t b);
        mk_swap = '{op: ladder_pkg::OP_SWAP, src_a: a, src_b: b, dst: b, dst2: a,
                    wr_cnt: 2'd2, key_step: 1'b0};
    endfunction

    always_comb
    begin
        case (step_idx)
            5'd0:  step = '{op: ladder_pkg::OP_ADD, src_a: ladder_pkg::A_K_NUM,
                           src_b: ladder_pkg::A_ZERO, dst: ladder_pkg::A_ZERO,
                           dst2: ladder_pkg::A_ZERO, wr_cnt: 2'd0, key_step: 1'b1};
            5'd1:  step = mk_swap(ladder_pkg::A_X2, ladder_pkg::A_X3);
            5'd2:  step = mk_swap(ladder_pkg::A_Z2, ladder_pkg::A_Z3);
            // doubling half
            5'd3:  step = mk(ladder_pkg::OP_ADD, ladder_pkg::A_X2, ladder_pkg::A_Z2, ladder_pkg::A_A);
            5'd4:  step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_A, ladder_pkg::A_A, ladder_pkg::A_AA);
            5'd5:  step = mk(ladder_pkg::OP_SUB, ladder_pkg::A_Z2, ladder_pkg::A_X2, ladder_pkg::A_B);
            5'd6:  step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_B, ladder_pkg::A_B, ladder_pkg::A_BB);
            5'd7:  step = mk(ladder_pkg::OP_SUB, ladder_pkg::A_BB, ladder_pkg::A_AA, ladder_pkg::A_E);
            5'd8:  step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_AA, ladder_pkg::A_BB, ladder_pkg::A_X2);
            5'd9:  step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_E, ladder_pkg::A_A24,
                             ladder_pkg::A_Z2TEMP);
            5'd10: step = mk(ladder_pkg::OP_ADD, ladder_pkg::A_AA, ladder_pkg::A_Z2TEMP,
                             ladder_pkg::A_Z2TEMP);
            5'd11: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_E, ladder_pkg::A_Z2TEMP,
                             ladder_pkg::A_Z2);
            // differential add half
            5'd12: step = mk(ladder_pkg::OP_ADD, ladder_pkg::A_X3, ladder_pkg::A_Z3, ladder_pkg::A_C);
            5'd13: step = mk(ladder_pkg::OP_SUB, ladder_pkg::A_Z3, ladder_pkg::A_X3, ladder_pkg::A_D);
            5'd14: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_C, ladder_pkg::A_B, ladder_pkg::A_CB);
            5'd15: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_D, ladder_pkg::A_A, ladder_pkg::A_DA);
            5'd16: step = mk(ladder_pkg::OP_ADD, ladder_pkg::A_DA, ladder_pkg::A_CB,
                             ladder_pkg::A_DACB);
            5'd17: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_DACB, ladder_pkg::A_DACB,
                             ladder_pkg::A_X3);
            5'd18: step = mk(ladder_pkg::OP_SUB, ladder_pkg::A_CB, ladder_pkg::A_DA,
                             ladder_pkg::A_DACBS);
            5'd19: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_DACBS, ladder_pkg::A_DACBS,
                             ladder_pkg::A_DACBS);
            5'd20: step = mk(ladder_pkg::OP_MUL, ladder_pkg::A_UNUM, ladder_pkg::A_DACBS,
                             ladder_pkg::A_Z3);
            default: step = '0;  // unused indexes
        endcase
    end

endmodule

// File: design/ladder_pkg.sv
// ladder sizes are fixed by curve25519; temporaries share RAM words, so step order matters
package ladder_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes and counts
    localparam int WORD_W    = 256;  // one field element
    localparam int ADDR_W    = 5;    // 32-word scalar RAM
    localparam int STEP_W    = 5;
    localparam int NUM_STEPS = 21;   // key fetch, 2 swaps, 18 arithmetic
    localparam int BIT_TOP   = 254;  // first scalar bit walked
    localparam int BIT_W     = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STEP_W-1:0] step_idx_t;
    typedef logic [BIT_W-1:0]  bit_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // RAM address map
    localparam addr_t A_UNUM  = 6;   // u coordinate of the input point
    localparam addr_t A_X2    = 7;
    localparam addr_t A_Z2    = 8;
    localparam addr_t A_X3    = 9;
    localparam addr_t A_Z3    = 10;
    localparam addr_t A_K_NUM = 11;  // scalar
    localparam addr_t A_ZERO  = 18;  // constant 0
    localparam addr_t A_A24   = 31;  // constant 121665

    localparam addr_t A_TMP0  = 20;
    localparam addr_t A_TMP1  = 21;
    localparam addr_t A_TMP2  = 22;
    localparam addr_t A_TMP3  = 23;
    localparam addr_t A_TMP4  = 24;

    // names used by the ladder formulas, several per temporary word
    localparam addr_t A_A      = A_TMP0;
    localparam addr_t A_DA     = A_TMP0;  // A is dead once DA is formed
    localparam addr_t A_B      = A_TMP1;
    localparam addr_t A_CB     = A_TMP1;
    localparam addr_t A_AA     = A_TMP2;
    localparam addr_t A_C      = A_TMP2;
    localparam addr_t A_DACBS  = A_TMP2;  // DA - CB, then squared in place
    localparam addr_t A_BB     = A_TMP3;
    localparam addr_t A_Z2TEMP = A_TMP3;
    localparam addr_t A_D      = A_TMP3;
    localparam addr_t A_DACB   = A_TMP3;  // DA + CB
    localparam addr_t A_E      = A_TMP4;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes and FSM states
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,   // src_b - src_a
        OP_MUL,
        OP_SWAP   // conditional swap on alu_req.swap
    } alu_op_e;

    typedef enum logic [2:0] {
        S_IDLE, S_RD_A, S_RD_B, S_WAIT, S_WR_1, S_WR_2, S_NEXT, S_DONE
    } seq_state_e;

    // one table step
    typedef struct packed {
        alu_op_e    op;
        addr_t      src_a;
        addr_t      src_b;
        addr_t      dst;       // gets res
        addr_t      dst2;      // gets res_swap, swap steps only
        logic [1:0] wr_cnt;    // writes after the result: 0, 1 or 2
        logic       key_step;  // result is the scalar word
    } step_t;

    typedef struct packed {
        logic    start;  // one-cycle strobe
        alu_op_e op;
        logic    swap;
    } alu_req_t;

    typedef struct packed {
        logic  vld;
        word_t res;
        word_t res_swap;
    } alu_rsp_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } ram_wr_t;

endpackage
